// ==== src/rv_isa_pkg.sv ====
/* RV32I encoding constants
   opcodes, ALU operations, branch funct3 codes and field widths */
`default_nettype none

package rv_isa_pkg;

   localparam int xlen       = 32;   // data and address width
   localparam int reg_addr_w = 5;    // register index

   typedef enum logic [6:0] {
      opc_load   = 7'b0000011,
      opc_store  = 7'b0100011,
      opc_op     = 7'b0110011,
      opc_op_imm = 7'b0010011,
      opc_lui    = 7'b0110111,
      opc_auipc  = 7'b0010111,
      opc_jal    = 7'b1101111,
      opc_jalr   = 7'b1100111,
      opc_branch = 7'b1100011
   } opcode_e;

   // msb mirrors instr[30], low bits mirror funct3
   typedef enum logic [3:0] {
      alu_add  = 4'b0000,
      alu_sll  = 4'b0001,
      alu_slt  = 4'b0010,
      alu_sltu = 4'b0011,
      alu_xor  = 4'b0100,
      alu_srl  = 4'b0101,
      alu_or   = 4'b0110,
      alu_and  = 4'b0111,
      alu_sub  = 4'b1000,
      alu_sra  = 4'b1101
   } alu_op_e;

   localparam logic [2:0] f3_beq  = 3'b000;
   localparam logic [2:0] f3_bne  = 3'b001;
   localparam logic [2:0] f3_blt  = 3'b100;
   localparam logic [2:0] f3_bge  = 3'b101;
   localparam logic [2:0] f3_bltu = 3'b110;
   localparam logic [2:0] f3_bgeu = 3'b111;

endpackage

`default_nettype wire

// ==== src/core_pkg.sv ====
/* core microarchitecture definitions
   control states, decoded instruction classes, reset PC */
`default_nettype none

package core_pkg;

   typedef enum logic [2:0] {
      st_fetch,
      st_wait_instr,
      st_decode,
      st_execute,
      st_memory,
      st_writeback
   } ctrl_state_e;

   localparam logic [rv_isa_pkg::xlen-1:0] reset_pc = '0;
   localparam int num_regs = 32;

   typedef enum logic [3:0] {
      cls_load,
      cls_store,
      cls_alu_reg,
      cls_alu_imm,
      cls_lui,
      cls_auipc,
      cls_jal,
      cls_jalr,
      cls_branch,
      cls_illegal   // unknown opcode, skipped
   } instr_class_e;

endpackage

`default_nettype wire

// ==== src/core_ctrl.sv ====
/* control FSM, steps one instruction through the stages
   and holds in the wait states until memory answers */
`default_nettype none

module core_ctrl (
   input  wire                     clk,
   input  wire                     reset,
   input  wire                     read_data_valid,
   input  wire core_pkg::instr_class_e iclass,
   output logic                    fetch_en,
   output logic                    decode_en,
   output logic                    exec_en,
   output logic                    mem_en,
   output logic                    wb_en,
   output core_pkg::ctrl_state_e   state
);
   import core_pkg::*;

   ctrl_state_e state_next;

   always_comb begin
      state_next = state;
      case (state)
         st_fetch:      state_next = st_wait_instr;
         st_wait_instr: begin
            if (read_data_valid) state_next = st_decode;
         end
         st_decode:     state_next = st_execute;
         st_execute:    state_next = st_memory;
         st_memory: begin
            // only a load waits for data here
            if (iclass != cls_load || read_data_valid) state_next = st_writeback;
         end
         st_writeback:  state_next = st_fetch;
         default:       state_next = st_fetch;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= st_fetch;
      end else begin
         state <= state_next;
      end
   end

   assign fetch_en  = (state == st_fetch);
   assign decode_en = (state == st_decode);   // register file read cycle
   assign exec_en   = (state == st_execute);
   assign mem_en    = (state == st_memory);
   assign wb_en     = (state == st_writeback);

endmodule

`default_nettype wire

// ==== src/fetch_unit.sv ====
/* program counter and instruction fetch
   holds the fetch request until the word returns */
`default_nettype none

module fetch_unit (
   input  wire                         clk,
   input  wire                         reset,
   input  wire                         fetch_en,
   input  wire                         wait_en,
   input  wire [rv_isa_pkg::xlen-1:0]  read_data,
   input  wire                         read_data_valid,
   input  wire                         redirect,
   input  wire [rv_isa_pkg::xlen-1:0]  redirect_pc,
   output logic                        fetch_req,
   output logic [rv_isa_pkg::xlen-1:0] fetch_addr,
   output logic [rv_isa_pkg::xlen-1:0] pc,
   output logic [rv_isa_pkg::xlen-1:0] pc_plus4,
   output logic [rv_isa_pkg::xlen-1:0] instr
);
   import rv_isa_pkg::*;
   import core_pkg::*;

   logic step_pending;   // sequential advance owed by the last instruction

   assign pc_plus4   = pc + xlen'(4);
   assign fetch_addr = {pc[xlen-1:2], 2'b00};

   always_ff @(posedge clk) begin
      if (reset) begin
         pc           <= reset_pc;
         fetch_req    <= 1'b0;
         step_pending <= 1'b0;
      end else begin
         fetch_req <= fetch_en | (wait_en & ~read_data_valid);
         if (redirect) begin   // jump or taken branch at writeback
            pc           <= redirect_pc;
            step_pending <= 1'b0;
         end else if (fetch_en && step_pending) begin
            pc           <= pc_plus4;
            step_pending <= 1'b0;
         end else if (wait_en && read_data_valid) begin
            step_pending <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wait_en && read_data_valid) instr <= read_data;
   end

endmodule

`default_nettype wire

// ==== src/decode_unit.sv ====
/* instruction decoder, classifies the opcode, builds the immediate
   and picks the ALU operation */
`default_nettype none

module decode_unit (
   input  wire                               clk,
   input  wire                               reset,
   input  wire                               decode_en,
   input  wire [rv_isa_pkg::xlen-1:0]        instr,
   output core_pkg::instr_class_e            iclass,
   output logic [rv_isa_pkg::xlen-1:0]       imm,
   output logic [rv_isa_pkg::reg_addr_w-1:0] rd,
   output logic [2:0]                        funct3,
   output rv_isa_pkg::alu_op_e               alu_op,
   output logic [rv_isa_pkg::reg_addr_w-1:0] rs1_addr,
   output logic [rv_isa_pkg::reg_addr_w-1:0] rs2_addr,
   output logic                              rd_en,
   output logic                              error_instruction
);
   import rv_isa_pkg::*;
   import core_pkg::*;

   instr_class_e    cls_d;
   logic [xlen-1:0] imm_d;
   alu_op_e         op_d;
   logic [2:0]      f3;

   function automatic alu_op_e arith_op(input logic alt, input logic [2:0] code);
      case (code)
         3'b000:  return alt ? alu_sub : alu_add;
         3'b001:  return alu_sll;
         3'b010:  return alu_slt;
         3'b011:  return alu_sltu;
         3'b100:  return alu_xor;
         3'b101:  return alt ? alu_sra : alu_srl;
         3'b110:  return alu_or;
         default: return alu_and;
      endcase
   endfunction

   assign f3       = instr[14:12];
   assign rs1_addr = instr[19:15];
   assign rs2_addr = instr[24:20];
   assign rd_en    = decode_en;

   always_comb begin
      cls_d = cls_illegal;
      imm_d = {{20{instr[31]}}, instr[31:20]};   // I format
      op_d  = alu_add;
      case (instr[6:0])
         opc_load:   cls_d = cls_load;
         opc_jalr:   cls_d = cls_jalr;
         opc_store: begin
            cls_d = cls_store;
            imm_d = {{20{instr[31]}}, instr[31:25], instr[11:7]};
         end
         opc_op: begin
            cls_d = cls_alu_reg;
            op_d  = arith_op(instr[30], f3);
         end
         opc_op_imm: begin
            cls_d = cls_alu_imm;
            op_d  = arith_op(instr[30] && f3 == 3'b101, f3);   // only srai uses bit 30
         end
         opc_lui, opc_auipc: begin
            cls_d = (instr[5]) ? cls_lui : cls_auipc;
            imm_d = {instr[31:12], 12'b0};
         end
         opc_jal: begin
            cls_d = cls_jal;
            imm_d = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
         end
         opc_branch: begin
            cls_d = cls_branch;
            imm_d = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            if (!f3[2]) op_d = alu_sub;   // beq, bne
            else op_d = f3[1] ? alu_sltu : alu_slt;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (decode_en) begin
         iclass <= cls_d;
         imm    <= imm_d;
         rd     <= instr[11:7];
         funct3 <= f3;
         alu_op <= op_d;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         error_instruction <= 1'b0;
      end else if (decode_en && cls_d == cls_illegal) begin
         error_instruction <= 1'b1;   // sticky
      end
   end

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
/* integer register file, two registered read ports and one write port */
`default_nettype none

module reg_file (
   input  wire                               clk,
   input  wire                               reset,
   input  wire                               rd_en,
   input  wire [rv_isa_pkg::reg_addr_w-1:0]  rs1_addr,
   input  wire [rv_isa_pkg::reg_addr_w-1:0]  rs2_addr,
   input  wire                               wr_en,
   input  wire [rv_isa_pkg::reg_addr_w-1:0]  wr_addr,
   input  wire [rv_isa_pkg::xlen-1:0]        wr_data,
   output logic [rv_isa_pkg::xlen-1:0]       rs1_data,
   output logic [rv_isa_pkg::xlen-1:0]       rs2_data
);
   import rv_isa_pkg::*;
   import core_pkg::*;

   logic [xlen-1:0] regs [num_regs];

   always_ff @(posedge clk) begin
      if (wr_en && wr_addr != '0) regs[wr_addr] <= wr_data;   // x0 stays zero
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rs1_data <= '0;
         rs2_data <= '0;
      end else if (rd_en) begin
         rs1_data <= (rs1_addr == '0) ? '0 : regs[rs1_addr];
         rs2_data <= (rs2_addr == '0) ? '0 : regs[rs2_addr];
      end
   end

endmodule

`default_nettype wire

// ==== src/alu_exec.sv ====
/* execute stage, operand select, ALU and branch compare,
   result registered for the later stages */
`default_nettype none

module alu_exec (
   input  wire                         clk,
   input  wire                         exec_en,
   input  wire core_pkg::instr_class_e iclass,
   input  wire rv_isa_pkg::alu_op_e    alu_op,
   input  wire [2:0]                   funct3,
   input  wire [rv_isa_pkg::xlen-1:0]  pc,
   input  wire [rv_isa_pkg::xlen-1:0]  imm,
   input  wire [rv_isa_pkg::xlen-1:0]  rs1_data,
   input  wire [rv_isa_pkg::xlen-1:0]  rs2_data,
   output logic [rv_isa_pkg::xlen-1:0] alu_result,
   output logic                        cmp_true
);
   import rv_isa_pkg::*;
   import core_pkg::*;

   logic [xlen-1:0] op_a;
   logic [xlen-1:0] op_b;
   logic [xlen-1:0] res;
   logic            taken;

   assign op_a = (iclass == cls_auipc) ? pc : rs1_data;
   assign op_b = (iclass == cls_alu_reg || iclass == cls_branch) ? rs2_data : imm;

   always_comb begin
      case (alu_op)
         alu_sub:  res = op_a - op_b;
         alu_sll:  res = op_a << op_b[4:0];
         alu_slt:  res = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         alu_sltu: res = {{(xlen-1){1'b0}}, op_a < op_b};
         alu_xor:  res = op_a ^ op_b;
         alu_srl:  res = op_a >> op_b[4:0];
         alu_sra:  res = $signed(op_a) >>> op_b[4:0];
         alu_or:   res = op_a | op_b;
         alu_and:  res = op_a & op_b;
         default:  res = op_a + op_b;   // add, address and auipc sums
      endcase
   end

   // decode chose sub, slt or sltu for a branch
   always_comb begin
      case (funct3)
         f3_beq:          taken = (res == '0);
         f3_bne:          taken = (res != '0);
         f3_blt, f3_bltu: taken = res[0];
         f3_bge, f3_bgeu: taken = ~res[0];
         default:         taken = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (exec_en) begin
         alu_result <= res;
         cmp_true   <= taken;
      end
   end

endmodule

`default_nettype wire

// ==== src/mem_wb_unit.sv ====
/* memory and writeback stages, load/store requests,
   register write and next-PC redirect */
`default_nettype none

module mem_wb_unit (
   input  wire                               clk,
   input  wire                               reset,
   input  wire                               mem_en,
   input  wire                               wb_en,
   input  wire core_pkg::instr_class_e       iclass,
   input  wire [rv_isa_pkg::reg_addr_w-1:0]  rd,
   input  wire [rv_isa_pkg::xlen-1:0]        imm,
   input  wire [rv_isa_pkg::xlen-1:0]        pc,
   input  wire [rv_isa_pkg::xlen-1:0]        pc_plus4,
   input  wire [rv_isa_pkg::xlen-1:0]        alu_result,
   input  wire                               cmp_true,
   input  wire [rv_isa_pkg::xlen-1:0]        rs2_data,
   input  wire [rv_isa_pkg::xlen-1:0]        read_data,
   input  wire                               read_data_valid,
   output logic                              load_req,
   output logic [rv_isa_pkg::xlen-1:0]       load_addr,
   output logic                              write_req,
   output logic [rv_isa_pkg::xlen-1:0]       write_addr,
   output logic [rv_isa_pkg::xlen-1:0]       write_data,
   output logic                              mem_done,
   output logic                              redirect,
   output logic [rv_isa_pkg::xlen-1:0]       redirect_pc,
   output logic                              wr_en,
   output logic [rv_isa_pkg::reg_addr_w-1:0] wr_addr,
   output logic [rv_isa_pkg::xlen-1:0]       wr_data
);
   import rv_isa_pkg::*;
   import core_pkg::*;

   logic            is_load;
   logic            is_store;
   logic [xlen-1:0] load_data;

   assign is_load   = (iclass == cls_load);
   assign is_store  = (iclass == cls_store);
   assign load_addr = {alu_result[xlen-1:2], 2'b00};
   assign mem_done  = mem_en & (~is_load | read_data_valid);

   always_ff @(posedge clk) begin
      if (reset) begin
         load_req  <= 1'b0;
         write_req <= 1'b0;
      end else begin
         load_req  <= mem_en & ~mem_done;    // held until the word returns
         write_req <= mem_en & is_store;     // one-cycle pulse in writeback
      end
   end

   always_ff @(posedge clk) begin
      if (mem_en && is_store) begin
         write_addr <= {alu_result[xlen-1:2], 2'b00};
         write_data <= rs2_data;
      end
      if (mem_en && is_load && read_data_valid) load_data <= read_data;
   end

   always_comb begin
      wr_en   = 1'b0;
      wr_data = alu_result;
      case (iclass)
         cls_alu_reg, cls_alu_imm, cls_auipc: wr_en = wb_en;
         cls_lui: begin
            wr_en   = wb_en;
            wr_data = imm;
         end
         cls_jal, cls_jalr: begin
            wr_en   = wb_en;
            wr_data = pc_plus4;   // link address
         end
         cls_load: begin
            wr_en   = wb_en;
            wr_data = load_data;
         end
         default: ;
      endcase
   end

   assign wr_addr     = rd;
   assign redirect    = wb_en & (iclass == cls_jal || iclass == cls_jalr ||
                                 (iclass == cls_branch && cmp_true));
   assign redirect_pc = (iclass == cls_jalr) ? {alu_result[xlen-1:1], 1'b0} : pc + imm;

endmodule

`default_nettype wire

// ==== src/rv_core_top.sv ====
/* multi-cycle RV32I core top, connects the stage units
   and shares the read port between fetch and load */
`default_nettype none

module rv_core_top (
   input  wire                         clk,
   input  wire                         reset,
   output logic                        read_req,
   output logic [rv_isa_pkg::xlen-1:0] read_addr,
   input  wire [rv_isa_pkg::xlen-1:0]  read_data,
   input  wire                         read_data_valid,
   output logic                        write_req,
   output logic [rv_isa_pkg::xlen-1:0] write_addr,
   output logic [rv_isa_pkg::xlen-1:0] write_data,
   output logic                        error_instruction
);
   import rv_isa_pkg::*;
   import core_pkg::*;

   ctrl_state_e           state;
   instr_class_e          iclass;
   alu_op_e               alu_op;
   logic                  fetch_en, decode_en, exec_en, mem_en, wb_en, wait_en;
   logic                  fetch_req, load_req, rd_en, cmp_true, redirect, wr_en;
   logic [xlen-1:0]       fetch_addr, load_addr, pc, pc_plus4, instr, imm;
   logic [xlen-1:0]       rs1_data, rs2_data, alu_result, redirect_pc, wr_data;
   logic [reg_addr_w-1:0] rd, rs1_addr, rs2_addr, wr_addr;
   logic [2:0]            funct3;

   assign wait_en   = (state == st_wait_instr);
   assign read_req  = fetch_req | load_req;   // never both at once
   assign read_addr = load_req ? load_addr : fetch_addr;

   core_ctrl ctrl_i (
      .clk, .reset, .read_data_valid, .iclass,
      .fetch_en, .decode_en, .exec_en, .mem_en, .wb_en, .state
   );

   fetch_unit fetch_i (
      .clk, .reset, .fetch_en, .wait_en, .read_data, .read_data_valid,
      .redirect, .redirect_pc, .fetch_req, .fetch_addr, .pc, .pc_plus4, .instr
   );

   decode_unit decode_i (
      .clk, .reset, .decode_en, .instr, .iclass, .imm, .rd, .funct3, .alu_op,
      .rs1_addr, .rs2_addr, .rd_en, .error_instruction
   );

   reg_file rf_i (
      .clk, .reset, .rd_en, .rs1_addr, .rs2_addr,
      .wr_en, .wr_addr, .wr_data, .rs1_data, .rs2_data
   );

   alu_exec alu_i (
      .clk, .exec_en, .iclass, .alu_op, .funct3, .pc, .imm,
      .rs1_data, .rs2_data, .alu_result, .cmp_true
   );

   mem_wb_unit mem_wb_i (
      .clk, .reset, .mem_en, .wb_en, .iclass, .rd, .imm, .pc, .pc_plus4,
      .alu_result, .cmp_true, .rs2_data, .read_data, .read_data_valid,
      .load_req, .load_addr, .write_req, .write_addr, .write_data,
      .mem_done (),
      .redirect, .redirect_pc, .wr_en, .wr_addr, .wr_data
   );

endmodule

`default_nettype wire

// ==== sim/rv_core_props.sv ====
/* bus protocol checks for the core top level */
`default_nettype none

module rv_core_props (
   input wire        clk,
   input wire        reset,
   input wire        read_req,
   input wire [31:0] read_addr,
   input wire        read_data_valid,
   input wire        write_req,
   input wire [31:0] write_addr,
   input wire        error_instruction
);

   // a waiting read keeps its request and address
   a_read_hold: assert property (@(posedge clk) disable iff (reset)
      read_req && !read_data_valid |=> read_req && $stable(read_addr))
      else $error("read_addr changed or read_req dropped while waiting");

   a_write_pulse: assert property (@(posedge clk) disable iff (reset)
      write_req |=> !write_req)
      else $error("write_req held for two cycles");

   a_read_aligned: assert property (@(posedge clk) disable iff (reset)
      read_req |-> read_addr[1:0] == 2'b00)
      else $error("read_addr not word aligned");

   a_write_aligned: assert property (@(posedge clk) disable iff (reset)
      write_req |-> write_addr[1:0] == 2'b00)
      else $error("write_addr not word aligned");

   // outputs quiet in the cycle after a reset edge
   a_reset_quiet: assert property (@(posedge clk)
      reset |=> !read_req && !write_req && !error_instruction)
      else $error("outputs not low after reset");

endmodule

`default_nettype wire

// ==== sim/tb_rv_core.sv ====
/* testbench for the RV32I core, memory model with random read delay,
   self-checking test program */
`default_nettype none

module tb_rv_core;
   import rv_isa_pkg::*;

   logic        clk;
   logic        reset;
   logic        read_req;
   logic [31:0] read_addr;
   logic [31:0] read_data;
   logic        read_data_valid;
   logic        write_req;
   logic [31:0] write_addr;
   logic [31:0] write_data;
   logic        error_instruction;

   logic [31:0] mem [512];
   logic [31:0] exp_addr [$];
   logic [31:0] exp_data [$];
   logic [31:0] pc_gen;
   logic [11:0] st_off;
   logic        busy;
   logic [1:0]  delay_left;
   logic [31:0] pend_addr;
   integer      seed;
   integer      rnd;
   int          store_idx;
   int          ill_idx;
   int          cycles;
   int          limit;

   rv_core_top dut_i (
      .clk, .reset, .read_req, .read_addr, .read_data, .read_data_valid,
      .write_req, .write_addr, .write_data, .error_instruction
   );

   bind rv_core_top rv_core_props props_i (
      .clk(clk), .reset(reset), .read_req(read_req), .read_addr(read_addr),
      .read_data_valid(read_data_valid), .write_req(write_req),
      .write_addr(write_addr), .error_instruction(error_instruction)
   );

   always #2 clk = ~clk;

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
      else fail_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   function automatic logic [31:0] fill_word(input logic [31:0] idx);
      return 32'h5a5a0000 ^ (idx * 32'h9e3779b1);
   endfunction

   function automatic logic [31:0] sext12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   // branch outcome per the ISA compare rules
   function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
      case (f3)
         3'b000:  return a == b;
         3'b001:  return a != b;
         3'b100:  return $signed(a) < $signed(b);
         3'b101:  return $signed(a) >= $signed(b);
         3'b110:  return a < b;
         default: return a >= b;
      endcase
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
   endfunction

   function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
   endfunction

   function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
   endfunction

   task automatic emit(input logic [31:0] word);
      mem[pc_gen[10:2]] = word;
      pc_gen = pc_gen + 32'd4;
   endtask

   // sw rs to the result area and queue the word it must write
   task automatic store_check(input logic [4:0] rs, input logic [31:0] value);
      emit(enc_s(st_off, rs, 5'd10));
      exp_addr.push_back(32'h300 + {20'b0, st_off});
      exp_data.push_back(value);
      st_off = st_off + 12'd4;
   endtask

   task automatic skip_store();
      emit(enc_s(st_off, 5'd13, 5'd10));   // on a skipped path, never written
      st_off = st_off + 12'd4;
   endtask

   task automatic op_reg(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rs1,
                         input logic [4:0] rs2, input logic [31:0] value);
      emit({f7, rs2, rs1, f3, 5'd7, opc_op});
      store_check(5'd7, value);
   endtask

   task automatic op_imm(input logic [2:0] f3, input logic [11:0] imm, input logic [4:0] rs1,
                         input logic [31:0] value);
      emit(enc_i(imm, rs1, f3, 5'd7, opc_op_imm));
      store_check(5'd7, value);
   endtask

   task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                              input logic [31:0] va, input logic [31:0] vb);
      emit(enc_b(13'd8, rs2, rs1, f3));
      if (branch_taken(f3, va, vb)) skip_store();
      else store_check(5'd13, 32'h5a);
   endtask

   task automatic build_program();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] here;
      a = 32'd100;
      b = 32'hfffffff9;
      pc_gen = 32'h0;
      st_off = 12'h0;
      for (int i = 0; i < 512; i++) mem[i] = fill_word(32'(i));
      emit(enc_i(12'd768, 5'd0, 3'b000, 5'd10, opc_op_imm));   // x10 result base
      emit(enc_i(12'd100, 5'd0, 3'b000, 5'd1, opc_op_imm));
      emit(enc_i(12'hff9, 5'd0, 3'b000, 5'd2, opc_op_imm));
      emit(enc_i(12'd3, 5'd0, 3'b000, 5'd8, opc_op_imm));
      emit(enc_i(12'h05a, 5'd0, 3'b000, 5'd13, opc_op_imm));   // marker
      emit(enc_i(12'd512, 5'd0, 3'b000, 5'd11, opc_op_imm));   // data area
      op_reg(7'h00, 3'b000, 5'd1, 5'd2, a + b);
      op_reg(7'h20, 3'b000, 5'd1, 5'd2, a - b);
      op_reg(7'h00, 3'b001, 5'd1, 5'd8, a << 3);
      op_reg(7'h00, 3'b010, 5'd2, 5'd1, 32'd1);
      op_reg(7'h00, 3'b011, 5'd2, 5'd1, 32'd0);
      op_reg(7'h00, 3'b100, 5'd1, 5'd2, a ^ b);
      op_reg(7'h00, 3'b101, 5'd2, 5'd8, b >> 3);
      op_reg(7'h20, 3'b101, 5'd2, 5'd8, 32'($signed(b) >>> 3));
      op_reg(7'h00, 3'b110, 5'd1, 5'd2, a | b);
      op_reg(7'h00, 3'b111, 5'd1, 5'd2, a & b);
      op_imm(3'b001, 12'h004, 5'd2, b << 4);
      op_imm(3'b101, 12'h01c, 5'd2, b >> 28);
      op_imm(3'b101, 12'h401, 5'd2, 32'($signed(b) >>> 1));
      op_imm(3'b100, 12'h0f0, 5'd1, a ^ sext12(12'h0f0));
      op_imm(3'b110, 12'h123, 5'd2, b | sext12(12'h123));
      op_imm(3'b111, 12'hff0, 5'd1, a & sext12(12'hff0));
      op_imm(3'b010, 12'hffd, 5'd2, 32'd1);
      op_imm(3'b011, 12'd50, 5'd1, 32'd0);
      op_imm(3'b000, 12'hf38, 5'd1, a + sext12(12'hf38));
      emit({20'h12345, 5'd7, opc_lui});
      store_check(5'd7, 32'h12345000);
      here = pc_gen;
      emit({20'h00001, 5'd7, opc_auipc});
      store_check(5'd7, here + 32'h1000);
      emit(enc_i(12'd0, 5'd11, 3'b010, 5'd9, opc_load));
      store_check(5'd9, fill_word(32'd128));
      emit(enc_i(12'd8, 5'd11, 3'b010, 5'd9, opc_load));
      store_check(5'd9, fill_word(32'd130));
      branch_case(3'b000, 5'd1, 5'd1, a, a);
      branch_case(3'b000, 5'd1, 5'd2, a, b);
      branch_case(3'b001, 5'd1, 5'd2, a, b);
      branch_case(3'b001, 5'd8, 5'd8, 32'd3, 32'd3);
      branch_case(3'b100, 5'd2, 5'd1, b, a);
      branch_case(3'b100, 5'd1, 5'd2, a, b);
      branch_case(3'b101, 5'd1, 5'd2, a, b);
      branch_case(3'b101, 5'd2, 5'd1, b, a);
      branch_case(3'b110, 5'd1, 5'd2, a, b);
      branch_case(3'b110, 5'd2, 5'd1, b, a);
      branch_case(3'b111, 5'd2, 5'd1, b, a);
      branch_case(3'b111, 5'd8, 5'd1, 32'd3, a);
      here = pc_gen;
      emit(enc_j(21'd8, 5'd14));
      skip_store();
      store_check(5'd14, here + 32'd4);
      here = pc_gen;   // jalr target sits three words on, odd offset 1
      emit(enc_i(here[11:0] + 12'd11, 5'd0, 3'b000, 5'd15, opc_op_imm));
      emit(enc_i(12'd1, 5'd15, 3'b000, 5'd16, opc_jalr));
      skip_store();
      store_check(5'd16, here + 32'd8);
      ill_idx = exp_addr.size();
      emit(32'h0000007f);
      store_check(5'd13, 32'h5a);
      emit(enc_j(21'd0, 5'd0));   // park
      limit = 20 * int'(pc_gen >> 2) * 8;
   endtask

   // memory model, one pending read, answered after 1 to 3 cycles
   always @(negedge clk) begin
      read_data_valid <= 1'b0;
      if (reset) begin
         busy <= 1'b0;
      end else if (busy) begin
         if (delay_left == 2'd1) begin
            read_data_valid <= 1'b1;
            read_data       <= mem[pend_addr[10:2]];
            busy            <= 1'b0;
         end else begin
            delay_left <= delay_left - 2'd1;
         end
      end else if (read_req && !read_data_valid) begin
         rnd = $random(seed);
         busy       <= 1'b1;
         pend_addr  <= read_addr;
         delay_left <= 2'(((rnd & 32'h7fffffff) % 3) + 1);
      end
   end

   always @(negedge clk) begin
      if (!reset && write_req) begin
         if (store_idx >= exp_addr.size()) begin
            fail_run($sformatf("unexpected store to 0x%h after the last checked store",
                               write_addr));
         end else begin
            check_value("write_addr", write_addr, exp_addr[store_idx]);
            check_value("write_data", write_data, exp_data[store_idx]);
            check_value("error_instruction", {31'b0, error_instruction},
                        {31'b0, store_idx >= ill_idx});
            mem[write_addr[10:2]] = write_data;
            store_idx = store_idx + 1;
         end
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (limit != 0 && cycles >= limit) begin
         fail_run("timeout, the program did not finish its stores");
      end
   end

   initial begin
      clk             = 1'b0;
      reset           = 1'b1;
      read_data       = '0;
      read_data_valid = 1'b0;
      busy            = 1'b0;
      delay_left      = 2'd0;
      pend_addr       = '0;
      seed            = 88926;
      store_idx       = 0;
      ill_idx         = 0;
      cycles          = 0;
      limit           = 0;
      build_program();
      repeat (2) @(negedge clk);
      reset = 1'b0;
      wait (store_idx == exp_addr.size());
      repeat (10) @(negedge clk);
      // error flag still set after the park loop
      assert (error_instruction === 1'b1) begin
         $display("All tests passed");
         $finish;
      end else begin
         fail_run($sformatf("[ERROR] error_instruction got 0x%h expected 0x1",
                            error_instruction));
      end
   end

endmodule

`default_nettype wire

// ==== rv_core.f ====
src/rv_isa_pkg.sv
src/core_pkg.sv
src/core_ctrl.sv
src/fetch_unit.sv
src/decode_unit.sv
src/reg_file.sv
src/alu_exec.sv
src/mem_wb_unit.sv
src/rv_core_top.sv
sim/rv_core_props.sv
sim/tb_rv_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_rv_core
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf $(BUILD_DIR)
